// File: mac_bus_pkg.sv
`default_nettype none

package mac_bus_pkg;

  // ============================================================
  // Processor bus widths
  // ============================================================
  typedef logic [23:1] word_addr_t;  // Word address, A23..A1
  typedef logic [15:0] bus_data_t;   // D15..D0
  typedef logic [7:0]  byte_t;       // Peripheral register value
  typedef logic [2:0]  ipl_t;        // IPL2..IPL0, active low

  // Device hit by the current address
  typedef enum logic [2:0] {
    DEV_NONE, DEV_RAM, DEV_ROM, DEV_SCC, DEV_VIA, DEV_IWM, DEV_SCSI
  } dev_sel_t;

  // RAM start, overlay on / overlay off
  localparam logic [23:0] RAM_LOW_BASE  = 24'h000000;
  localparam logic [23:0] RAM_HIGH_BASE = 24'h600000;

  // Autovectored interrupt levels
  localparam ipl_t IPL_NONE = 3'b111;
  localparam ipl_t IPL_VIA  = 3'b110;  // Level 1
  localparam ipl_t IPL_SCC  = 3'b101;  // Level 2

endpackage

`default_nettype wire

// File: mac_reg_pkg.sv
`default_nettype none

package mac_reg_pkg;

  // ============================================================
  // VIA register map, index is A12..A9
  // ============================================================
  typedef logic [3:0] via_reg_t;

  localparam via_reg_t VIA_PORTB = 4'h0;
  localparam via_reg_t VIA_DDRB  = 4'h2;
  localparam via_reg_t VIA_T2_LO = 4'h8;
  localparam via_reg_t VIA_T2_HI = 4'h9;
  localparam via_reg_t VIA_SR    = 4'hA;
  localparam via_reg_t VIA_ACR   = 4'hB;
  localparam via_reg_t VIA_IFR   = 4'hD;
  localparam via_reg_t VIA_IER   = 4'hE;
  localparam via_reg_t VIA_PORTA = 4'hF;

  typedef logic [6:0] via_irq_t;  // IFR / IER without bit 7

  // Interrupt flag positions
  localparam int INT_ONESEC   = 0;
  localparam int INT_VBLANK   = 1;
  localparam int INT_KEYREADY = 2;
  localparam int INT_KEYBIT   = 3;
  localparam int INT_KEYCLK   = 4;
  localparam int INT_T2       = 5;
  localparam int INT_T1       = 6;

  // ACR[4:2] shift register modes
  localparam logic [2:0] ACR_SR_EXT_IN = 3'b011;  // Shift in, external clock
  localparam logic [2:0] ACR_SR_OUT    = 3'b111;  // Shift out

  // ============================================================
  // SCC
  // ============================================================
  typedef logic [3:0] scc_reg_t;
  localparam logic [7:0] WR15_RESET = 8'hF8;

  // Port reset values, PA4 low = overlay on
  localparam logic [7:0] PORTA_RESET       = 8'h6F;
  localparam logic [7:0] PORTB_RESET       = 8'hFF;
  localparam int         PORTA_OVERLAY_BIT = 4;

endpackage

`default_nettype wire

// File: cpu_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if;
  import mac_bus_pkg::*;

  logic        via_accept;  // VIA cycle accepted, one clock
  logic        scc_accept;  // SCC cycle accepted, one clock
  logic        done;        // Peripheral cycle ends, ack falling
  logic        rw;          // 1 = read
  logic [12:1] reg_addr;    // Register select bits
  logic        uds_n;
  logic        lds_n;
  byte_t       wdata_hi;    // Peripherals sit on D15..D8

  modport ctrl (output via_accept, scc_accept, done, rw, reg_addr, uds_n, lds_n,
                wdata_hi);
  modport dev  (input via_accept, scc_accept, done, rw, reg_addr, uds_n, lds_n,
                wdata_hi);

endinterface

`default_nettype wire

// File: bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bus_ctrl (
  input  wire                     clk_cpu,
  input  wire                     reset,
  input  wire                     i_req,
  input  wire                     i_rw,
  input  mac_bus_pkg::word_addr_t i_addr,
  input  wire                     i_uds_n,
  input  wire                     i_lds_n,
  input  mac_bus_pkg::bus_data_t  i_wdata,
  input  wire                     i_overlay,
  input  mac_bus_pkg::byte_t      i_via_rdata,
  input  mac_bus_pkg::byte_t      i_scc_rdata,
  input  wire                     i_via_irq,
  input  wire                     i_scc_irq,
  output logic                    o_ack,
  output mac_bus_pkg::bus_data_t  o_rdata,
  output mac_bus_pkg::ipl_t       o_ipl_n,
  output logic                    o_ram_cs,
  output logic                    o_rom_cs,
  cpu_bus_if.ctrl                 bus
);
  import mac_bus_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_ACK, ST_RELEASE} ack_state_t;

  ack_state_t state;
  dev_sel_t   dev_sel;  // Decoded from live address
  dev_sel_t   cyc_dev;  // Held for the whole cycle
  logic       accept;

  // ============================================================
  // Address decode, overlay moves RAM down to 0
  // ============================================================
  always_comb begin
    dev_sel = DEV_NONE;
    if (i_req) begin
      casez (i_addr[23:20])
        4'b00??: dev_sel = i_overlay ? DEV_RAM : DEV_ROM;
        4'b0100: if (!i_addr[17]) dev_sel = DEV_ROM;
        4'b0101: if (i_addr[19:12] == 8'h80) dev_sel = DEV_SCSI;
        4'b0110: if (!i_overlay) dev_sel = DEV_RAM;
        4'b10?1: dev_sel = DEV_SCC;       // Read and write halves
        4'b1101: dev_sel = DEV_IWM;
        4'b1110: dev_sel = DEV_VIA;
        default: dev_sel = DEV_NONE;
      endcase
    end
  end

  assign o_ram_cs = (dev_sel == DEV_RAM);
  assign o_rom_cs = (dev_sel == DEV_ROM);

  // Four-phase handshake
  assign accept = (state == ST_IDLE) && i_req;
  assign o_ack  = (state != ST_IDLE);

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      state   <= ST_IDLE;
      cyc_dev <= DEV_NONE;
    end else begin
      case (state)
        ST_IDLE: if (i_req) begin
          state   <= ST_ACK;
          cyc_dev <= dev_sel;
        end
        ST_ACK:     state <= i_req ? ST_RELEASE : ST_IDLE;  // Master may stretch
        ST_RELEASE: if (!i_req) state <= ST_IDLE;
        default:    state <= ST_IDLE;
      endcase
    end
  end

  // Peripheral side
  assign bus.via_accept = accept && (dev_sel == DEV_VIA);
  assign bus.scc_accept = accept && (dev_sel == DEV_SCC);
  assign bus.done       = o_ack && !i_req && (cyc_dev == DEV_SCC || cyc_dev == DEV_VIA);
  assign bus.rw         = i_rw;
  assign bus.reg_addr   = i_addr[12:1];
  assign bus.uds_n      = i_uds_n;
  assign bus.lds_n      = i_lds_n;
  assign bus.wdata_hi   = i_wdata[15:8];

  // Read mux, 8-bit devices on the high byte
  always_comb begin
    case (cyc_dev)
      DEV_VIA: o_rdata = {i_via_rdata, 8'hEF};
      DEV_SCC: o_rdata = {i_scc_rdata, 8'hEF};
      default: o_rdata = '0;
    endcase
  end

  // VIA wins over SCC
  assign o_ipl_n = i_via_irq ? IPL_VIA : i_scc_irq ? IPL_SCC : IPL_NONE;

endmodule

`default_nettype wire

// File: mac_via.sv
`timescale 1ns/1ps
`default_nettype none

module mac_via #(
  parameter int TIMER_DIV_BITS  = 5,   // Timer tick every 2^n clocks
  parameter int VBLANKS_PER_SEC = 60
) (
  input  wire                clk_cpu,
  input  wire                reset,
  cpu_bus_if.dev             bus,
  input  wire                i_vsync,
  input  mac_bus_pkg::byte_t i_kbd_data,
  input  wire                i_kbd_strobe,
  output mac_bus_pkg::byte_t o_rdata,
  output logic               o_irq,
  output logic               o_overlay,
  output mac_bus_pkg::byte_t o_kbd_data,
  output logic               o_kbd_strobe
);
  import mac_bus_pkg::*;
  import mac_reg_pkg::*;

  localparam int VCNT_W = $clog2(VBLANKS_PER_SEC);

  via_reg_t                  reg_idx;
  byte_t                     wdata;
  byte_t                     porta, portb, acr, sr, t2_latch_lo;
  logic                      ddrb0;
  via_irq_t                  ifr, ier;
  logic [15:0]               t2_count;
  logic                      t2_armed;
  logic [TIMER_DIV_BITS-1:0] div_cnt;
  logic [VCNT_W-1:0]         vsync_cnt;
  logic [1:0]                vsync_q;
  logic                      wr_en, rd_en, load_t2, sr_wr, kbd_load, tick, vblank_fall;

  assign reg_idx     = bus.reg_addr[12:9];
  assign wdata       = bus.wdata_hi;
  assign wr_en       = bus.via_accept && !bus.uds_n && !bus.rw;  // VIA on upper byte only
  assign rd_en       = bus.via_accept && !bus.uds_n && bus.rw;
  assign load_t2     = wr_en && (reg_idx == VIA_T2_HI);
  assign sr_wr       = wr_en && (reg_idx == VIA_SR);
  assign kbd_load    = i_kbd_strobe && (acr[4:2] == ACR_SR_EXT_IN);
  assign tick        = (div_cnt == '0);
  assign vblank_fall = vsync_q[1] && !vsync_q[0];

  // ============================================================
  // Control registers and flags
  // ============================================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      porta        <= PORTA_RESET;
      portb        <= PORTB_RESET;
      ddrb0        <= 1'b1;
      acr          <= '0;
      ifr          <= '0;
      ier          <= '0;
      t2_armed     <= 1'b0;
      div_cnt      <= '0;
      vsync_cnt    <= '0;
      vsync_q      <= '0;
      o_kbd_strobe <= 1'b0;
    end else begin
      div_cnt      <= div_cnt + 1'b1;  // Free running prescaler
      vsync_q      <= {vsync_q[0], i_vsync};
      o_kbd_strobe <= sr_wr && (acr[4:2] == ACR_SR_OUT);
      if (wr_en) begin
        case (reg_idx)
          VIA_PORTB: portb <= wdata;
          VIA_DDRB:  ddrb0 <= wdata[0];
          VIA_T2_HI: begin           // Arms timer, clears old flag
            t2_armed    <= 1'b1;
            ifr[INT_T2] <= 1'b0;
          end
          VIA_SR:    if (acr[4:2] == ACR_SR_OUT) ifr[INT_KEYREADY] <= 1'b1;
          VIA_ACR:   acr <= wdata;
          VIA_IFR:   ifr <= ifr & ~wdata[6:0];  // Write 1 to clear
          VIA_IER:   ier <= wdata[7] ? (ier | wdata[6:0]) : (ier & ~wdata[6:0]);
          VIA_PORTA: porta <= wdata;
          default:   ;
        endcase
      end
      if (rd_en) begin
        case (reg_idx)          // Read side effects
          VIA_PORTB: ifr[INT_KEYCLK:INT_KEYBIT] <= 2'b00;
          VIA_T2_LO: ifr[INT_T2] <= 1'b0;
          VIA_SR:    ifr[INT_KEYREADY] <= 1'b0;
          VIA_PORTA: ifr[INT_VBLANK:INT_ONESEC] <= 2'b00;
          default:   ;
        endcase
      end
      // Vertical blank and one-second tick
      if (vblank_fall) begin
        ifr[INT_VBLANK] <= 1'b1;
        vsync_cnt       <= vsync_cnt + 1'b1;
        if (vsync_cnt == VCNT_W'(VBLANKS_PER_SEC - 1)) begin
          ifr[INT_ONESEC] <= 1'b1;
          vsync_cnt       <= '0;
        end
      end
      if (tick && !load_t2 && t2_armed && t2_count == '0) begin
        ifr[INT_T2] <= 1'b1;     // One shot
        t2_armed    <= 1'b0;
      end
      if (kbd_load) ifr[INT_KEYREADY] <= 1'b1;
      ifr[INT_T1] <= 1'b0;       // No timer 1
    end
  end

  // Timer 2 count, latch and shift register data
  always_ff @(posedge clk_cpu) begin
    if (wr_en && reg_idx == VIA_T2_LO) t2_latch_lo <= wdata;
    if (load_t2) t2_count <= {wdata, t2_latch_lo};
    else if (tick) t2_count <= t2_count - 1'b1;
    if (sr_wr) sr <= wdata;
    if (kbd_load) sr <= i_kbd_data;   // Byte from keyboard
  end

  // Register read mux
  always_comb begin
    case (reg_idx)
      VIA_PORTB: o_rdata = portb;
      VIA_DDRB:  o_rdata = {7'b1000011, ddrb0};
      4'h3:      o_rdata = 8'h7F;                      // DDRA fixed
      VIA_T2_LO: o_rdata = t2_count[7:0];
      VIA_T2_HI: o_rdata = t2_count[15:8];
      VIA_SR:    o_rdata = sr;
      VIA_ACR:   o_rdata = acr;
      VIA_IFR:   o_rdata = {|(ifr & ier), ifr};        // Bit 7 = any enabled
      VIA_IER:   o_rdata = {1'b0, ier};
      VIA_PORTA: o_rdata = {1'b1, porta[6:0]};         // SCC wait/req high
      default:   o_rdata = '0;
    endcase
  end

  assign o_irq      = |(ifr & ier);
  assign o_overlay  = ~porta[PORTA_OVERLAY_BIT];
  assign o_kbd_data = sr;

endmodule

`default_nettype wire

// File: scc_mouse.sv
`timescale 1ns/1ps
`default_nettype none

module scc_mouse (
  input  wire                clk_cpu,
  input  wire                reset,
  cpu_bus_if.dev             bus,
  input  wire                i_mouse_x1,
  input  wire                i_mouse_y1,
  output mac_bus_pkg::byte_t o_rdata,
  output logic               o_irq
);
  import mac_bus_pkg::*;
  import mac_reg_pkg::*;

  // Channel index 1 = A (mouse X), 0 = B (mouse Y)
  logic [1:0] rs;                // A2 data/cmd, A1 channel
  byte_t      wdata;
  scc_reg_t   rindex, rindex_latch;
  byte_t      wr15 [2];          // Bit 3 DCD interrupt enable
  byte_t      wr1 [2];           // Bit 0 external interrupt enable
  logic [5:0] wr9;               // Bit 3 master interrupt enable
  logic [1:0] mouse, dcd_latch, latch_open, ex_irq_ip;
  logic [1:0] wreg, do_extreset, dcd_ip, do_latch, chan_reset;
  logic       scc_wr, wr9_wr, reset_scc;
  byte_t      rr0, rr2_b, rr3_a;
  logic [2:0] vec_stat;

  assign rs     = bus.reg_addr[2:1];
  assign wdata  = bus.wdata_hi;
  assign mouse  = {i_mouse_x1, i_mouse_y1};
  assign scc_wr = bus.scc_accept && (!bus.uds_n || !bus.lds_n) && !bus.rw && !rs[1];
  assign wr9_wr = scc_wr && (rindex == 4'd9);   // WR9 shared by both channels

  // Hardware reset from WR9 acts like the reset pin
  assign reset_scc = reset || (wr9_wr && wdata[7:6] == 2'b11);

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      wreg[i]        = scc_wr && (rs[0] == i[0]);
      do_extreset[i] = wreg[i] && (rindex == '0) && (wdata[5:3] == 3'b010);
      dcd_ip[i]      = (mouse[i] != dcd_latch[i]) && wr15[i][3];
      do_latch[i]    = latch_open[i] && dcd_ip[i];
      chan_reset[i]  = reset_scc || (wr9_wr && wdata[7:6] == (2'b01 << i));
    end
  end

  // ============================================================
  // Write registers
  // ============================================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      wr9 <= '0;
    end else if (wr9_wr) begin
      wr9 <= wdata[5:0];
    end
    for (int i = 0; i < 2; i++) begin
      if (chan_reset[i]) wr1[i] <= {2'b00, wr1[i][5], 2'b00, wr1[i][2], 2'b00};  // Keep 5, 2
      else if (wreg[i] && rindex == 4'd1) wr1[i] <= wdata;
    end
  end

  // Pointer applies once the cycle ends
  always_ff @(posedge clk_cpu) begin
    if (reset) rindex <= '0;
    else if (bus.done) rindex <= rindex_latch;
  end

  always_ff @(posedge clk_cpu) begin
    if (reset_scc) begin
      rindex_latch <= '0;
      ex_irq_ip    <= '0;
      latch_open   <= 2'b11;
      dcd_latch    <= '0;
      wr15[0]      <= WR15_RESET;
      wr15[1]      <= WR15_RESET;
    end else begin
      // Any command access drops back to register 0
      if (bus.scc_accept && !rs[1]) begin
        rindex_latch <= '0;
        if (!bus.rw && rindex == '0) rindex_latch <= {wdata[5:3] == 3'b001, wdata[2:0]};
      end
      for (int i = 0; i < 2; i++) begin
        if (wreg[i] && rindex == 4'd15) wr15[i] <= wdata;
        if (do_extreset[i]) begin        // Reset ext/status reopens latch
          latch_open[i] <= 1'b1;
          ex_irq_ip[i]  <= 1'b0;
        end else if (do_latch[i]) begin
          latch_open[i] <= 1'b0;
          if (wr1[i][0]) ex_irq_ip[i] <= 1'b1;
        end
        if (do_latch[i]) dcd_latch[i] <= mouse[i];
      end
    end
  end

  // ============================================================
  // Read registers
  // ============================================================
  assign rr0      = {4'b0100, wr15[rs[0]][3] ? dcd_latch[rs[0]] : mouse[rs[0]], 3'b100};
  assign vec_stat = ex_irq_ip[1] ? 3'b101 : ex_irq_ip[0] ? 3'b001 : 3'b011;
  assign rr2_b    = {4'b0000, vec_stat, 1'b0};
  assign rr3_a    = {4'b0000, ex_irq_ip[1], 2'b00, ex_irq_ip[0]};

  always_comb begin
    case (rindex)
      4'd0:    o_rdata = rr0;
      4'd2:    o_rdata = rs[0] ? 8'h00 : rr2_b;  // Status only on B
      4'd3:    o_rdata = rs[0] ? rr3_a : 8'h00;  // Pending only on A
      default: o_rdata = '0;
    endcase
  end

  assign o_irq = wr9[3] && (|ex_irq_ip);

endmodule

`default_nettype wire

// File: mac_io.sv
`timescale 1ns/1ps
`default_nettype none

module mac_io #(
  parameter int TIMER_DIV_BITS  = 5,
  parameter int VBLANKS_PER_SEC = 60
) (
  input  wire                     clk_cpu,
  input  wire                     reset,
  // Processor bus
  input  wire                     i_req,
  input  wire                     i_rw,
  input  mac_bus_pkg::word_addr_t i_addr,
  input  wire                     i_uds_n,
  input  wire                     i_lds_n,
  input  mac_bus_pkg::bus_data_t  i_wdata,
  output logic                    o_ack,
  output mac_bus_pkg::bus_data_t  o_rdata,
  output mac_bus_pkg::ipl_t       o_ipl_n,
  output logic                    o_ram_cs,
  output logic                    o_rom_cs,
  // Video, mouse, keyboard
  input  wire                     i_vsync,
  input  wire                     i_mouse_x1,
  input  wire                     i_mouse_y1,
  input  mac_bus_pkg::byte_t      i_kbd_data,
  input  wire                     i_kbd_strobe,
  output mac_bus_pkg::byte_t      o_kbd_data,
  output logic                    o_kbd_strobe
);
  import mac_bus_pkg::*;

  byte_t via_rdata, scc_rdata;
  logic  via_irq, scc_irq, overlay;

  cpu_bus_if bus_if ();

  // ============================================================
  // Decoder, VIA, SCC
  // ============================================================
  bus_ctrl bus_ctrl_i (
    .clk_cpu, .reset, .i_req, .i_rw, .i_addr, .i_uds_n, .i_lds_n, .i_wdata,
    .i_overlay(overlay), .i_via_rdata(via_rdata), .i_scc_rdata(scc_rdata),
    .i_via_irq(via_irq), .i_scc_irq(scc_irq),
    .o_ack, .o_rdata, .o_ipl_n, .o_ram_cs, .o_rom_cs, .bus(bus_if.ctrl)
  );

  mac_via #(.TIMER_DIV_BITS(TIMER_DIV_BITS), .VBLANKS_PER_SEC(VBLANKS_PER_SEC)) mac_via_i (
    .clk_cpu, .reset, .bus(bus_if.dev), .i_vsync, .i_kbd_data, .i_kbd_strobe,
    .o_rdata(via_rdata), .o_irq(via_irq), .o_overlay(overlay), .o_kbd_data, .o_kbd_strobe
  );

  scc_mouse scc_mouse_i (
    .clk_cpu, .reset, .bus(bus_if.dev), .i_mouse_x1, .i_mouse_y1,
    .o_rdata(scc_rdata), .o_irq(scc_irq)
  );

endmodule

`default_nettype wire

// File: mac_io_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mac_io_sva (
  input wire                clk_cpu,
  input wire                reset,
  input wire                i_req,
  input wire                o_ack,
  input wire                o_ram_cs,
  input wire                o_rom_cs,
  input wire                i_via_irq,
  input mac_bus_pkg::ipl_t  o_ipl_n
);
  import mac_bus_pkg::*;

  // ============================================================
  // Handshake
  // ============================================================
  a_ack_follows_req: assert property (@(posedge clk_cpu) disable iff (reset)
    (i_req && !o_ack) |=> o_ack) else $error("ack missing one cycle after req");

  a_ack_holds: assert property (@(posedge clk_cpu) disable iff (reset)
    (o_ack && i_req) |=> o_ack) else $error("ack dropped while req high");

  // Quiet outputs in reset
  a_reset_quiet: assert property (@(posedge clk_cpu)
    (reset && $past(reset)) |-> (!o_ack && !o_ram_cs && !o_rom_cs))
    else $error("ack or select active in reset");

  // VIA level masks the SCC level
  a_ipl_prio: assert property (@(posedge clk_cpu) disable iff (reset)
    i_via_irq |-> (o_ipl_n != IPL_SCC)) else $error("SCC level shown over VIA");

endmodule

bind bus_ctrl mac_io_sva mac_io_sva_i (
  .clk_cpu(clk_cpu), .reset(reset), .i_req(i_req), .o_ack(o_ack),
  .o_ram_cs(o_ram_cs), .o_rom_cs(o_rom_cs), .i_via_irq(i_via_irq), .o_ipl_n(o_ipl_n)
);

`default_nettype wire

// File: tb_mac_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mac_io;
  import mac_bus_pkg::*;
  import mac_reg_pkg::*;

  typedef enum {OP_WR, OP_RD, OP_SEL, OP_IPL, OP_VSYNC, OP_MOUSE, OP_KEY, OP_KOUT,
                OP_T2} op_t;
  typedef struct {
    op_t         op;
    logic [23:0] addr;   // Byte address
    bus_data_t   data;
    bus_data_t   exp;
    bus_data_t   mask;
  } step_t;

  localparam logic [23:0] SCC_WR_A = 24'hB00002;  // Command, channel A
  localparam logic [23:0] SCC_WR_B = 24'hB00000;
  localparam logic [23:0] SCC_RD_A = 24'h900002;
  localparam logic [23:0] SCC_RD_B = 24'h900000;

  logic       clk_cpu = 1'b0;
  logic       reset, i_req, i_rw, i_uds_n, i_lds_n, i_vsync, i_mouse_x1, i_mouse_y1;
  logic       i_kbd_strobe, o_ack, o_ram_cs, o_rom_cs, o_kbd_strobe;
  word_addr_t i_addr;
  bus_data_t  i_wdata, o_rdata;
  ipl_t       o_ipl_n;
  byte_t      i_kbd_data, o_kbd_data;
  step_t      steps[$];
  int         errors = 0;
  int         cycles = 0;
  int         limit = 0;
  int         strobes = 0;

  mac_io #(.TIMER_DIV_BITS(5), .VBLANKS_PER_SEC(60)) mac_io_i (.*);

  always #5 clk_cpu = ~clk_cpu;

  // Cycle budget and strobe pulse counter
  always @(posedge clk_cpu) begin
    cycles <= cycles + 1;
    if (o_kbd_strobe) strobes <= strobes + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  // ============================================================
  // Compare tasks
  // ============================================================
  task automatic check_data(input string what, input bus_data_t got, exp, mask);
    if ((got & mask) !== (exp & mask)) begin
      errors++;
      $display("CHECK FAILED t=%0t: %s data %h expected %h mask %h", $time, what, got,
               exp, mask);
    end
  endtask

  task automatic check_ipl(input string what, input ipl_t got, exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t: %s ipl %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_byte(input string what, input byte_t got, exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t: %s byte %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic [23:0] via_addr(input via_reg_t idx);
    return 24'hE00000 | (24'(idx) << 9);   // Index on A12..A9
  endfunction

  task automatic add(input op_t op, input logic [23:0] addr, input bus_data_t data,
                     input bus_data_t exp, input bus_data_t mask);
    step_t s;
    s.op   = op;
    s.addr = addr;
    s.data = data;
    s.exp  = exp;
    s.mask = mask;
    steps.push_back(s);
  endtask

  // Four-phase access, entered and left 1 ns after an edge
  task automatic bus_cycle(input logic rw, input logic [23:0] addr, input bus_data_t wdata,
                           output bus_data_t rdata, output logic ram_cs, rom_cs);
    i_req   = 1'b1;
    i_rw    = rw;
    i_addr  = addr[23:1];
    i_uds_n = 1'b0;
    i_lds_n = 1'b0;
    i_wdata = wdata;
    do begin
      @(posedge clk_cpu);
      #1;
    end while (!o_ack);
    rdata  = o_rdata;        // Valid while ack is high
    ram_cs = o_ram_cs;
    rom_cs = o_rom_cs;
    i_req  = 1'b0;
    do begin
      @(posedge clk_cpu);
      #1;
    end while (o_ack);
  endtask

  task automatic tick(input int n);
    repeat (n) begin
      @(posedge clk_cpu);
      #1;
    end
  endtask

  task automatic run_step(input step_t s, input int k);
    bus_data_t rd;
    logic      ram, rom;
    int        n, c0;
    string     what;
    what = $sformatf("step %0d", k);
    case (s.op)
      OP_WR:  bus_cycle(1'b0, s.addr, s.data, rd, ram, rom);
      OP_RD: begin
        bus_cycle(1'b1, s.addr, 16'h0, rd, ram, rom);
        if (s.mask != '0) check_data(what, rd, s.exp, s.mask);  // Mask 0 reads only clear flags
      end
      OP_SEL: begin
        bus_cycle(1'b1, s.addr, 16'h0, rd, ram, rom);
        check_bit({what, " ram_cs"}, ram, s.exp[1]);
        check_bit({what, " rom_cs"}, rom, s.exp[0]);
      end
      OP_IPL: check_ipl(what, o_ipl_n, ipl_t'(s.exp[2:0]));
      OP_VSYNC: begin
        repeat (int'(s.data)) begin
          i_vsync = 1'b1;
          tick(1);
          i_vsync = 1'b0;
          tick(3);           // Edge detect plus flag register
        end
      end
      OP_MOUSE: begin
        i_mouse_x1 = s.data[0];
        tick(2);
      end
      OP_KEY: begin
        i_kbd_data   = s.data[7:0];
        i_kbd_strobe = 1'b1;
        tick(1);
        i_kbd_strobe = 1'b0;
        tick(1);
      end
      OP_KOUT: begin
        c0 = strobes;
        bus_cycle(1'b0, via_addr(VIA_SR), s.data, rd, ram, rom);
        tick(3);
        check_bit({what, " single strobe"}, (strobes - c0) == 1, 1'b1);
        check_byte({what, " kbd data"}, o_kbd_data, s.data[15:8]);
      end
      OP_T2: begin
        bus_cycle(1'b0, via_addr(VIA_T2_HI), s.data, rd, ram, rom);
        n = 1;               // Edges since the accept edge
        while (o_ipl_n != IPL_VIA && n < (int'(s.exp) + 2) * 32) begin
          tick(1);
          n++;
        end
        check_bit({what, " t2 not early"}, n >= int'(s.exp) * 32, 1'b1);
        check_bit({what, " t2 not late"}, n <= (int'(s.exp) + 1) * 32 + 4, 1'b1);
      end
      default: ;
    endcase
  endtask

  // ============================================================
  // Stimulus table
  // ============================================================
  task automatic build_steps();
    // Overlay decode
    add(OP_SEL, RAM_LOW_BASE, 0, 16'h0002, 0);
    add(OP_SEL, 24'h400000, 0, 16'h0001, 0);
    add(OP_WR, via_addr(VIA_PORTA), 16'h7F00, 0, 0);     // PA4 high, overlay off
    add(OP_SEL, RAM_LOW_BASE, 0, 16'h0001, 0);
    add(OP_SEL, RAM_HIGH_BASE, 0, 16'h0002, 0);
    // IER / IFR
    add(OP_IPL, 0, 0, 16'(IPL_NONE), 0);
    add(OP_WR, via_addr(VIA_IER), 16'h8600, 0, 0);
    add(OP_RD, via_addr(VIA_IER), 0, 16'h06EF, 16'hFFFF);
    add(OP_WR, via_addr(VIA_IER), 16'h0400, 0, 0);
    add(OP_RD, via_addr(VIA_IER), 0, 16'h02EF, 16'hFFFF);
    add(OP_IPL, 0, 0, 16'(IPL_NONE), 0);
    add(OP_VSYNC, 0, 1, 0, 0);
    add(OP_IPL, 0, 0, 16'(IPL_VIA), 0);
    add(OP_RD, via_addr(VIA_IFR), 0, 16'h82EF, 16'hFFFF);
    add(OP_WR, via_addr(VIA_IFR), 16'h0200, 0, 0);
    add(OP_RD, via_addr(VIA_IFR), 0, 16'h00EF, 16'hFFFF);
    add(OP_IPL, 0, 0, 16'(IPL_NONE), 0);
    // Vertical blank and one second
    add(OP_VSYNC, 0, 1, 0, 0);
    add(OP_RD, via_addr(VIA_IFR), 0, 16'h82EF, 16'hFFFF);
    add(OP_RD, via_addr(VIA_PORTA), 0, 16'hFFEF, 16'hFFFF);
    add(OP_RD, via_addr(VIA_IFR), 0, 16'h00EF, 16'hFFFF);
    add(OP_VSYNC, 0, 57, 0, 0);
    add(OP_RD, via_addr(VIA_IFR), 0, 16'h0200, 16'h0300);
    add(OP_VSYNC, 0, 1, 0, 0);                          // Edge 60
    add(OP_RD, via_addr(VIA_IFR), 0, 16'h0300, 16'h0300);
    add(OP_RD, via_addr(VIA_PORTA), 0, 16'hFFEF, 16'hFFFF);
    // Keyboard shift register
    add(OP_WR, via_addr(VIA_ACR), 16'h0C00, 0, 0);
    add(OP_KEY, 0, 16'h00A5, 0, 0);
    add(OP_RD, via_addr(VIA_IFR), 0, 16'h0400, 16'h0400);
    add(OP_RD, via_addr(VIA_SR), 0, 16'hA5EF, 16'hFFFF);
    add(OP_RD, via_addr(VIA_IFR), 0, 16'h0000, 16'h0400);
    add(OP_WR, via_addr(VIA_ACR), 16'h1C00, 0, 0);
    add(OP_KOUT, 0, 16'h3C00, 0, 0);
    add(OP_RD, via_addr(VIA_SR), 0, 16'h3CEF, 16'hFFFF);
    add(OP_WR, via_addr(VIA_ACR), 16'h0000, 0, 0);
    // Mouse interrupt through the SCC
    add(OP_WR, via_addr(VIA_IER), 16'h7F00, 0, 0);
    add(OP_IPL, 0, 0, 16'(IPL_NONE), 0);
    add(OP_WR, SCC_WR_A, 16'h0F00, 0, 0);
    add(OP_WR, SCC_WR_A, 16'h0800, 0, 0);               // WR15 DCD enable
    add(OP_WR, SCC_WR_A, 16'h0100, 0, 0);
    add(OP_WR, SCC_WR_A, 16'h0100, 0, 0);               // WR1 ext int enable
    add(OP_WR, SCC_WR_A, 16'h0900, 0, 0);
    add(OP_WR, SCC_WR_A, 16'h0800, 0, 0);               // WR9 MIE
    add(OP_MOUSE, 0, 16'h0001, 0, 0);
    add(OP_IPL, 0, 0, 16'(IPL_SCC), 0);
    add(OP_WR, SCC_WR_A, 16'h0300, 0, 0);
    add(OP_RD, SCC_RD_A, 0, 16'h08EF, 16'hFFFF);        // RR3A pending
    add(OP_WR, SCC_WR_B, 16'h0200, 0, 0);
    add(OP_RD, SCC_RD_B, 0, 16'h0AEF, 16'hFFFF);        // RR2B status 101
    add(OP_WR, SCC_WR_A, 16'h1000, 0, 0);               // Reset ext/status
    add(OP_IPL, 0, 0, 16'(IPL_NONE), 0);
    add(OP_WR, SCC_WR_A, 16'h0F00, 0, 0);
    add(OP_WR, SCC_WR_A, 16'h0000, 0, 0);               // WR15 cleared
    add(OP_WR, SCC_WR_A, 16'h0900, 0, 0);
    add(OP_WR, SCC_WR_A, 16'hC000, 0, 0);               // Hardware reset
    add(OP_MOUSE, 0, 16'h0000, 0, 0);
    add(OP_RD, SCC_RD_A, 0, 16'h4CEF, 16'hFFFF);        // Latched DCD again
    add(OP_IPL, 0, 0, 16'(IPL_NONE), 0);
    // Timer 2, count of 100
    add(OP_WR, via_addr(VIA_IER), 16'hA000, 0, 0);
    add(OP_WR, via_addr(VIA_T2_LO), 16'h6400, 0, 0);
    add(OP_T2, 0, 16'h0000, 16'd100, 0);
    add(OP_IPL, 0, 0, 16'(IPL_VIA), 0);
    add(OP_RD, via_addr(VIA_T2_LO), 0, 0, 0);
    add(OP_IPL, 0, 0, 16'(IPL_NONE), 0);
  endtask

  initial begin
    reset        = 1'b1;
    i_req        = 1'b0;
    i_rw         = 1'b1;
    i_addr       = '0;
    i_uds_n      = 1'b1;
    i_lds_n      = 1'b1;
    i_wdata      = '0;
    i_vsync      = 1'b0;
    i_mouse_x1   = 1'b0;
    i_mouse_y1   = 1'b0;
    i_kbd_data   = '0;
    i_kbd_strobe = 1'b0;
    build_steps();
    limit = 40 * steps.size() + 40000;
    tick(2);
    reset = 1'b0;
    check_bit("ack after reset", o_ack, 1'b0);
    check_bit("kbd strobe after reset", o_kbd_strobe, 1'b0);
    check_bit("ram_cs after reset", o_ram_cs, 1'b0);
    check_bit("rom_cs after reset", o_rom_cs, 1'b0);
    check_ipl("ipl after reset", o_ipl_n, IPL_NONE);
    foreach (steps[k]) run_step(steps[k], k);
    $display("Checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mac_io.f
mac_bus_pkg.sv
mac_reg_pkg.sv
cpu_bus_if.sv
bus_ctrl.sv
mac_via.sv
scc_mouse.sv
mac_io.sv
mac_io_sva.sv
tb_mac_io.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mac_io testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mac_io -o sim_tb -f mac_io.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "sim passed"; then
  exit 0
fi
exit 1
